//--- src/decode_params.svh
/*
 * Width definitions for the decode stage.
 * Operand, PC, instruction and register file sizes.
 */

`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Operand width of the integer datapath.
`define DATA_WIDTH 64

// Program counter width.
`define ADDR_WIDTH 64

// Register address width and register count.
`define REG_ADDR_W 5
`define REG_COUNT 32

// Fetched instruction width.
`define INSTR_WIDTH 32

`endif

//--- src/isa_pkg.sv
/*
 * RV64I instruction set types: field widths, major opcodes,
 * immediate formats, ALU operations and result selection codes.
 */

`include "decode_params.svh"

package isa_pkg;

    typedef logic [`INSTR_WIDTH - 1:0] instr_t;
    typedef logic [6:0]                opcode_t;
    typedef logic [2:0]                funct3_t;
    typedef logic [`REG_ADDR_W - 1:0]  reg_addr_t;
    typedef logic [`DATA_WIDTH - 1:0]  xdata_t;
    typedef logic [`ADDR_WIDTH - 1:0]  addr_t;
    typedef logic [2:0]                imm_src_t;
    typedef logic [4:0]                alu_op_t;
    typedef logic [2:0]                result_src_t;

    // Supported major opcodes.
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // Immediate formats.
    localparam imm_src_t IMM_I = 3'd0;
    localparam imm_src_t IMM_S = 3'd1;
    localparam imm_src_t IMM_B = 3'd2;
    localparam imm_src_t IMM_U = 3'd3;
    localparam imm_src_t IMM_J = 3'd4;

    // ALU operations, arithmetic first and branch compares after.
    localparam alu_op_t ALU_ADD  = 5'd0;
    localparam alu_op_t ALU_SUB  = 5'd1;
    localparam alu_op_t ALU_SLL  = 5'd2;
    localparam alu_op_t ALU_SLT  = 5'd3;
    localparam alu_op_t ALU_SLTU = 5'd4;
    localparam alu_op_t ALU_XOR  = 5'd5;
    localparam alu_op_t ALU_SRL  = 5'd6;
    localparam alu_op_t ALU_SRA  = 5'd7;
    localparam alu_op_t ALU_OR   = 5'd8;
    localparam alu_op_t ALU_AND  = 5'd9;
    localparam alu_op_t ALU_EQ   = 5'd10;
    localparam alu_op_t ALU_NE   = 5'd11;
    localparam alu_op_t ALU_LT   = 5'd12;
    localparam alu_op_t ALU_GE   = 5'd13;
    localparam alu_op_t ALU_LTU  = 5'd14;
    localparam alu_op_t ALU_GEU  = 5'd15;

    // Writeback result selection.
    localparam result_src_t RES_ALU       = 3'd0;
    localparam result_src_t RES_MEM       = 3'd1;
    localparam result_src_t RES_PC_PLUS4  = 3'd2;
    localparam result_src_t RES_IMM       = 3'd3;
    localparam result_src_t RES_PC_TARGET = 3'd4;

endpackage

//--- src/pipeline_pkg.sv
/*
 * Bundles passed between pipeline stages: decoded control,
 * writeback request and the decode/execute register contents.
 */

package pipeline_pkg;

    // Control bundle. All zero means a bubble.
    typedef struct packed {
        isa_pkg::result_src_t result_src;
        isa_pkg::alu_op_t     alu_control;
        logic                 mem_we;
        logic                 reg_we;
        logic                 alu_src;
        logic                 branch;
        logic                 jump;
    } ctrl_bundle_t;

    // Writeback request into the register file.
    typedef struct packed {
        logic                we;
        isa_pkg::reg_addr_t  rd_addr;
        isa_pkg::xdata_t     data;
    } wb_port_t;

    // Everything the execute stage receives from decode.
    typedef struct packed {
        ctrl_bundle_t        ctrl;
        isa_pkg::addr_t      pc;
        isa_pkg::addr_t      pc_plus4;
        isa_pkg::xdata_t     imm_ext;
        isa_pkg::xdata_t     rs1_data;
        isa_pkg::xdata_t     rs2_data;
        isa_pkg::reg_addr_t  rs1_addr;
        isa_pkg::reg_addr_t  rs2_addr;
        isa_pkg::reg_addr_t  rd_addr;
        isa_pkg::funct3_t    func3;
    } decode_out_t;

endpackage

//--- src/control_unit.sv
/*
 * Main decoder and ALU decoder for the RV64I base set.
 * Unsupported opcodes give an all-zero bundle.
 */

`timescale 1ns/1ns

module control_unit (
    input  isa_pkg::opcode_t          i_op,
    input  isa_pkg::funct3_t          i_func3,
    input  logic                      i_func7_5,
    output pipeline_pkg::ctrl_bundle_t o_ctrl,
    output isa_pkg::imm_src_t         o_imm_src
);

    // Instruction classes seen by the ALU decoder.
    localparam logic [1:0] ALU_CLASS_ADD    = 2'd0;
    localparam logic [1:0] ALU_CLASS_REG    = 2'd1;
    localparam logic [1:0] ALU_CLASS_IMM    = 2'd2;
    localparam logic [1:0] ALU_CLASS_BRANCH = 2'd3;

    pipeline_pkg::ctrl_bundle_t s_main;
    logic [1:0]                 s_alu_class;
    isa_pkg::alu_op_t           s_alu_control;

    // ----------------------------------------------------------
    // Main decoder.
    // ----------------------------------------------------------
    always_comb begin
        s_main      = '0;
        o_imm_src   = isa_pkg::IMM_I;
        s_alu_class = ALU_CLASS_ADD;
        case (i_op)
            isa_pkg::OP_REG: begin
                s_main.reg_we = 1'b1;
                s_alu_class   = ALU_CLASS_REG;
            end
            isa_pkg::OP_IMM: begin
                s_main.reg_we  = 1'b1;
                s_main.alu_src = 1'b1;
                s_alu_class    = ALU_CLASS_IMM;
            end
            isa_pkg::OP_LOAD: begin
                s_main.reg_we     = 1'b1;
                s_main.alu_src    = 1'b1;
                s_main.result_src = isa_pkg::RES_MEM;
            end
            isa_pkg::OP_STORE: begin
                s_main.mem_we  = 1'b1;
                s_main.alu_src = 1'b1;
                o_imm_src      = isa_pkg::IMM_S;
            end
            isa_pkg::OP_BRANCH: begin
                s_main.branch = 1'b1;
                o_imm_src     = isa_pkg::IMM_B;
                s_alu_class   = ALU_CLASS_BRANCH;
            end
            isa_pkg::OP_JAL: begin
                s_main.reg_we     = 1'b1;
                s_main.jump       = 1'b1;
                s_main.result_src = isa_pkg::RES_PC_PLUS4;
                o_imm_src         = isa_pkg::IMM_J;
            end
            isa_pkg::OP_JALR: begin
                // Target is rs1 + imm, formed in the ALU.
                s_main.reg_we     = 1'b1;
                s_main.jump       = 1'b1;
                s_main.alu_src    = 1'b1;
                s_main.result_src = isa_pkg::RES_PC_PLUS4;
            end
            isa_pkg::OP_LUI: begin
                s_main.reg_we     = 1'b1;
                s_main.result_src = isa_pkg::RES_IMM;
                o_imm_src         = isa_pkg::IMM_U;
            end
            isa_pkg::OP_AUIPC: begin
                s_main.reg_we     = 1'b1;
                s_main.result_src = isa_pkg::RES_PC_TARGET;
                o_imm_src         = isa_pkg::IMM_U;
            end
            default: ;
        endcase
    end

    // ----------------------------------------------------------
    // ALU decoder.
    // ----------------------------------------------------------
    always_comb begin
        s_alu_control = isa_pkg::ALU_ADD;
        if (s_alu_class == ALU_CLASS_BRANCH) begin
            case (i_func3)
                3'b001:  s_alu_control = isa_pkg::ALU_NE;
                3'b100:  s_alu_control = isa_pkg::ALU_LT;
                3'b101:  s_alu_control = isa_pkg::ALU_GE;
                3'b110:  s_alu_control = isa_pkg::ALU_LTU;
                3'b111:  s_alu_control = isa_pkg::ALU_GEU;
                default: s_alu_control = isa_pkg::ALU_EQ;
            endcase
        end else if (s_alu_class != ALU_CLASS_ADD) begin
            case (i_func3)
                3'b000: begin
                    // Immediate form has no subtract.
                    if ((s_alu_class == ALU_CLASS_REG) && i_func7_5) begin
                        s_alu_control = isa_pkg::ALU_SUB;
                    end
                end
                3'b001:  s_alu_control = isa_pkg::ALU_SLL;
                3'b010:  s_alu_control = isa_pkg::ALU_SLT;
                3'b011:  s_alu_control = isa_pkg::ALU_SLTU;
                3'b100:  s_alu_control = isa_pkg::ALU_XOR;
                3'b101:  s_alu_control = i_func7_5 ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
                3'b110:  s_alu_control = isa_pkg::ALU_OR;
                default: s_alu_control = isa_pkg::ALU_AND;
            endcase
        end
    end

    always_comb begin
        o_ctrl             = s_main;
        o_ctrl.alu_control = s_alu_control;
    end

endmodule

//--- src/extend_imm.sv
/*
 * Immediate assembly for the I, S, B, U and J formats,
 * sign-extended to the operand width.
 */

`timescale 1ns/1ns

`include "decode_params.svh"

module extend_imm (
    input  isa_pkg::imm_src_t        i_imm_src,
    input  logic [`INSTR_WIDTH-8:0]  i_imm,
    output isa_pkg::xdata_t          o_imm_ext
);

    // Field bit n of i_imm is instruction bit n + 7.
    logic s_sign;

    assign s_sign = i_imm[24];

    always_comb begin
        case (i_imm_src)
            isa_pkg::IMM_I: begin
                o_imm_ext = {{(`DATA_WIDTH - 12){s_sign}}, i_imm[24:13]};
            end
            isa_pkg::IMM_S: begin
                o_imm_ext = {{(`DATA_WIDTH - 12){s_sign}}, i_imm[24:18], i_imm[4:0]};
            end
            isa_pkg::IMM_B: begin
                o_imm_ext = {{(`DATA_WIDTH - 12){s_sign}}, i_imm[0], i_imm[23:18],
                             i_imm[4:1], 1'b0};
            end
            isa_pkg::IMM_U: begin
                // Upper 20 bits into the low word, then extended.
                o_imm_ext = {{(`DATA_WIDTH - 32){s_sign}}, i_imm[24:5], 12'b0};
            end
            isa_pkg::IMM_J: begin
                o_imm_ext = {{(`DATA_WIDTH - 20){s_sign}}, i_imm[12:5], i_imm[13],
                             i_imm[23:14], 1'b0};
            end
            default: begin
                o_imm_ext = '0;
            end
        endcase
    end

endmodule

//--- src/register_file.sv
/*
 * Integer register file, x0 fixed at zero.
 * Two combinational reads with writeback bypass.
 */

`timescale 1ns/1ns

`include "decode_params.svh"

module register_file (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  pipeline_pkg::wb_port_t i_wb,
    input  isa_pkg::reg_addr_t     i_rs1_addr,
    input  isa_pkg::reg_addr_t     i_rs2_addr,
    output isa_pkg::xdata_t        o_rs1_data,
    output isa_pkg::xdata_t        o_rs2_data
);

    // Only x1..x31 are stored.
    isa_pkg::xdata_t r_regs [1:`REG_COUNT-1];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                r_regs[i] <= '0;
            end
        end else if (i_wb.we && (i_wb.rd_addr != '0)) begin
            r_regs[i_wb.rd_addr] <= i_wb.data;
        end
    end

    // Same-cycle write is forwarded to the reader.
    function automatic isa_pkg::xdata_t read_port(input isa_pkg::reg_addr_t addr);
        isa_pkg::xdata_t data;
        if (addr == '0) begin
            data = '0;
        end else if (i_wb.we && (i_wb.rd_addr == addr)) begin
            data = i_wb.data;
        end else begin
            data = r_regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1_addr);
        o_rs2_data = read_port(i_rs2_addr);
    end

endmodule

//--- src/preg_decode.sv
/*
 * Decode/execute pipeline register.
 * Reset clears all fields, flush clears the control bundle.
 */

`timescale 1ns/1ns

module preg_decode (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_flush,
    input  pipeline_pkg::decode_out_t i_next,
    output pipeline_pkg::decode_out_t o_decode
);

    // ----------------------------------------------------------
    // Registered boundary to execute.
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_decode <= '0;
        end else begin
            o_decode <= i_next;
            // A bubble keeps its operands so the slot stays traceable.
            if (i_flush) begin
                o_decode.ctrl <= '0;
            end
        end
    end

endmodule

//--- src/decode_stage.sv
/*
 * Decode stage top level: field split, control decode,
 * immediate extension, register read and pipeline register.
 */

`timescale 1ns/1ns

module decode_stage (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  isa_pkg::instr_t           i_instr,
    input  isa_pkg::addr_t            i_pc,
    input  isa_pkg::addr_t            i_pc_plus4,
    input  pipeline_pkg::wb_port_t    i_wb,
    input  logic                      i_flush,
    output pipeline_pkg::decode_out_t o_decode,
    output isa_pkg::reg_addr_t        o_rs1_addr,
    output isa_pkg::reg_addr_t        o_rs2_addr
);

    // ----------------------------------------------------------
    // Instruction fields.
    // ----------------------------------------------------------
    isa_pkg::opcode_t   s_op;
    isa_pkg::funct3_t   s_func3;
    logic               s_func7_5;
    logic [24:0]        s_imm_data;
    isa_pkg::reg_addr_t s_rs1_addr;
    isa_pkg::reg_addr_t s_rs2_addr;
    isa_pkg::reg_addr_t s_rd_addr;

    // Decoded values.
    pipeline_pkg::ctrl_bundle_t s_ctrl;
    isa_pkg::imm_src_t          s_imm_src;
    isa_pkg::xdata_t            s_imm_ext;
    isa_pkg::xdata_t            s_rs1_data;
    isa_pkg::xdata_t            s_rs2_data;
    pipeline_pkg::decode_out_t  s_next;

    assign s_op       = i_instr[6:0];
    assign s_func3    = i_instr[14:12];
    assign s_func7_5  = i_instr[30];
    assign s_imm_data = i_instr[31:7];
    assign s_rs1_addr = i_instr[19:15];
    assign s_rs2_addr = i_instr[24:20];
    assign s_rd_addr  = i_instr[11:7];

    // ----------------------------------------------------------
    // Functional units.
    // ----------------------------------------------------------
    control_unit cu0 (
        .i_op      (s_op),
        .i_func3   (s_func3),
        .i_func7_5 (s_func7_5),
        .o_ctrl    (s_ctrl),
        .o_imm_src (s_imm_src)
    );

    extend_imm ei0 (
        .i_imm_src (s_imm_src),
        .i_imm     (s_imm_data),
        .o_imm_ext (s_imm_ext)
    );

    register_file reg_file0 (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wb       (i_wb),
        .i_rs1_addr (s_rs1_addr),
        .i_rs2_addr (s_rs2_addr),
        .o_rs1_data (s_rs1_data),
        .o_rs2_data (s_rs2_data)
    );

    // Unregistered stage result.
    always_comb begin
        s_next.ctrl     = s_ctrl;
        s_next.pc       = i_pc;
        s_next.pc_plus4 = i_pc_plus4;
        s_next.imm_ext  = s_imm_ext;
        s_next.rs1_data = s_rs1_data;
        s_next.rs2_data = s_rs2_data;
        s_next.rs1_addr = s_rs1_addr;
        s_next.rs2_addr = s_rs2_addr;
        s_next.rd_addr  = s_rd_addr;
        s_next.func3    = s_func3;
    end

    preg_decode preg_d (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_flush  (i_flush),
        .i_next   (s_next),
        .o_decode (o_decode)
    );

    // Hazard unit sees the source addresses without delay.
    assign o_rs1_addr = s_rs1_addr;
    assign o_rs2_addr = s_rs2_addr;

endmodule

//--- verification/tb_clock_gen.sv
/*
 * Free-running testbench clock.
 */

`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

//--- verification/decode_stage_asserts.sv
/*
 * Concurrent checks on the decode/execute register,
 * bound into the decode stage.
 */

`timescale 1ns/1ns

module decode_stage_asserts (
    input logic                      i_clk,
    input logic                      i_reset,
    input logic                      i_flush,
    input isa_pkg::addr_t            i_pc_plus4,
    input pipeline_pkg::decode_out_t o_decode
);

    // Bubble after reset or flush.
    ctrl_cleared: assert property (@(posedge i_clk)
        (i_reset || i_flush) |=> (o_decode.ctrl == '0))
        else $error("control bundle not cleared after reset or flush");

    // One cycle of latency on pc_plus4.
    pc_plus4_follows: assert property (@(posedge i_clk)
        !i_reset |=> (o_decode.pc_plus4 == $past(i_pc_plus4)))
        else $error("pc_plus4 did not follow the input by one cycle");

    // x0 always reads zero.
    x0_reads_zero: assert property (@(posedge i_clk)
        (o_decode.rs1_addr == '0) |-> (o_decode.rs1_data == '0))
        else $error("rs1 data not zero for register x0");

endmodule

bind decode_stage decode_stage_asserts u_decode_asserts (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_flush    (i_flush),
    .i_pc_plus4 (i_pc_plus4),
    .o_decode   (o_decode)
);

//--- verification/decode_stage_tb.sv
/*
 * Testbench for the decode stage: reset state, register file
 * writes and bypass, case file decode checks and flush.
 */

`timescale 1ns/1ns

module decode_stage_tb;

    logic                      clk;
    logic                      reset;
    isa_pkg::instr_t           instr;
    isa_pkg::addr_t            pc;
    isa_pkg::addr_t            pc_plus4;
    pipeline_pkg::wb_port_t    wb;
    logic                      flush;
    pipeline_pkg::decode_out_t dec;
    isa_pkg::reg_addr_t        rs1_addr_comb;
    isa_pkg::reg_addr_t        rs2_addr_comb;

    isa_pkg::xdata_t reg_model [0:31];
    logic [31:0]     lfsr_state;
    logic            edge_timed_out;
    int              case_count;

    tb_clock_gen #(.PERIOD_NS(100)) clk_gen (
        .o_clk (clk)
    );

    decode_stage i_decode_stage (
        .i_clk      (clk),
        .i_reset    (reset),
        .i_instr    (instr),
        .i_pc       (pc),
        .i_pc_plus4 (pc_plus4),
        .i_wb       (wb),
        .i_flush    (flush),
        .o_decode   (dec),
        .o_rs1_addr (rs1_addr_comb),
        .o_rs2_addr (rs2_addr_comb)
    );

    // ------------------------------------------------------------
    // Helpers.
    // ------------------------------------------------------------
    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task take_bits(input int count, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[62:0], lfsr_state[0]};
        end
    endtask

    task report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Each edge has its own timeout; inputs change 10 ns later.
    task wait_edges(input int count);
        for (int i = 0; i < count; i++) begin
            edge_timed_out = 1'b0;
            fork
                begin
                    @(posedge clk);
                end
                begin
                    #1000;
                    edge_timed_out = 1'b1;
                end
            join_any
            disable fork;
            if (edge_timed_out) begin
                report_failure("timeout: no rising clock edge within 1000 ns");
            end
        end
        #10;
    endtask

    function automatic isa_pkg::instr_t make_rtype(input int rs1, input int rs2);
        return {7'b0, 5'(rs2), 5'(rs1), 3'b000, 5'd0, 7'b0110011};
    endfunction

    // ------------------------------------------------------------
    // Compare tasks.
    // ------------------------------------------------------------
    task check_ctrl(input string name, input pipeline_pkg::ctrl_bundle_t got,
                    input pipeline_pkg::ctrl_bundle_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task check_data(input string name, input isa_pkg::xdata_t got,
                    input isa_pkg::xdata_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task check_addr(input string name, input isa_pkg::addr_t got,
                    input isa_pkg::addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task check_reg_addr(input string name, input isa_pkg::reg_addr_t got,
                        input isa_pkg::reg_addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task check_funct3(input string name, input isa_pkg::funct3_t got,
                      input isa_pkg::funct3_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task check_operands(input isa_pkg::instr_t word);
        check_data("o_decode.rs1_data", dec.rs1_data, reg_model[word[19:15]]);
        check_data("o_decode.rs2_data", dec.rs2_data, reg_model[word[24:20]]);
    endtask

    // Reads every register once, two per instruction.
    task check_reg_pairs;
        for (int a = 0; a < 32; a += 2) begin
            instr = make_rtype(a, a + 1);
            wait_edges(1);
            check_operands(instr);
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus.
    // ------------------------------------------------------------
    initial begin
        int              fd;
        int              fields;
        string           line;
        logic [63:0]     rnd;
        logic [15:0]     raw_ctrl;
        isa_pkg::instr_t c_instr;
        logic            c_flush;
        isa_pkg::xdata_t c_imm;

        lfsr_state  = 32'hba24_b6a0;
        reset       = 1'b1;
        instr       = '0;
        pc          = '0;
        pc_plus4    = '0;
        wb          = '0;
        flush       = 1'b0;
        case_count  = 0;
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = '0;
        end

        wait_edges(4);
        reset = 1'b0;
        check_ctrl("o_decode.ctrl", dec.ctrl, '0);

        // All registers read zero after reset.
        check_reg_pairs();

        // Fill every register, x0 included, with random data.
        for (int a = 0; a < 32; a++) begin
            take_bits(64, rnd);
            wb.we      = 1'b1;
            wb.rd_addr = 5'(a);
            wb.data    = rnd;
            instr      = '0;
            if (a != 0) begin
                reg_model[a] = rnd;
            end
            wait_edges(1);
        end
        wb = '0;
        for (int a = 0; a < 32; a++) begin
            instr = make_rtype(a, 31 - a);
            wait_edges(1);
            check_operands(instr);
        end

        // Same-cycle write and read of x7 sees the new value.
        take_bits(64, rnd);
        wb.we      = 1'b1;
        wb.rd_addr = 5'd7;
        wb.data    = rnd;
        instr      = make_rtype(7, 7);
        wait_edges(1);
        check_data("o_decode.rs1_data", dec.rs1_data, rnd);
        check_data("o_decode.rs2_data", dec.rs2_data, rnd);
        reg_model[7] = rnd;
        wb = '0;

        fd = $fopen("verification/decode_cases.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the case file verification/decode_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            if (line.len() < 8 || line.substr(0, 0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %b %h %h", c_instr, c_flush, raw_ctrl, c_imm);
            if (fields != 4) begin
                report_failure($sformatf("malformed case line: %s", line));
            end
            take_bits(62, rnd);
            pc       = {rnd[61:0], 2'b00};
            pc_plus4 = pc + 64'd4;
            instr    = c_instr;
            flush    = c_flush;
            #1;
            check_reg_addr("o_rs1_addr", rs1_addr_comb, c_instr[19:15]);
            check_reg_addr("o_rs2_addr", rs2_addr_comb, c_instr[24:20]);
            wait_edges(1);
            check_ctrl("o_decode.ctrl", dec.ctrl,
                       pipeline_pkg::ctrl_bundle_t'(raw_ctrl[12:0]));
            check_data("o_decode.imm_ext", dec.imm_ext, c_imm);
            check_addr("o_decode.pc", dec.pc, pc);
            check_addr("o_decode.pc_plus4", dec.pc_plus4, pc_plus4);
            check_reg_addr("o_decode.rd_addr", dec.rd_addr, c_instr[11:7]);
            check_reg_addr("o_decode.rs1_addr", dec.rs1_addr, c_instr[19:15]);
            check_reg_addr("o_decode.rs2_addr", dec.rs2_addr, c_instr[24:20]);
            check_funct3("o_decode.func3", dec.func3, c_instr[14:12]);
            check_operands(c_instr);
            flush = 1'b0;
            case_count++;
        end
        $fclose(fd);
        if (case_count == 0) begin
            report_failure("the case file held no test cases");
        end

        // Reset with live registers and a full pipeline register.
        reset = 1'b1;
        wait_edges(4);
        reset = 1'b0;
        check_ctrl("o_decode.ctrl", dec.ctrl, '0);
        check_addr("o_decode.pc", dec.pc, '0);
        check_data("o_decode.imm_ext", dec.imm_ext, '0);
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = '0;
        end
        check_reg_pairs();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+src
src/isa_pkg.sv
src/pipeline_pkg.sv
src/control_unit.sv
src/extend_imm.sv
src/register_file.sv
src/preg_decode.sv
src/decode_stage.sv
verification/tb_clock_gen.sv
verification/decode_stage_asserts.sv
verification/decode_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

sim_out=$( { verilator --binary --timing --assert -f compile.f \
    --top-module decode_stage_tb -o decode_stage_sim \
    && ./obj_dir/decode_stage_sim; } 2>&1 )
echo "$sim_out"

echo "$sim_out" | grep -qx "Simulation PASSED" && exit 0 || exit 1

//--- verification/decode_cases.txt
# instr(hex) flush(bin) ctrl(hex: result_src alu_control mem_we reg_we alu_src branch jump)
# imm_ext(hex) expected one cycle after the instruction is presented
002081B3 0 0008 0000000000000002
402081B3 0 0028 0000000000000402
002091B3 0 0048 0000000000000002
0020A1B3 0 0068 0000000000000002
0020B1B3 0 0088 0000000000000002
0020C1B3 0 00A8 0000000000000002
0020D1B3 0 00C8 0000000000000002
4020D1B3 0 00E8 0000000000000402
0020E1B3 0 0108 0000000000000002
0020F1B3 0 0128 0000000000000002
FFF08293 0 000C FFFFFFFFFFFFFFFF
4030D293 0 00EC 0000000000000403
40008293 0 000C 0000000000000400
FF813303 0 040C FFFFFFFFFFFFFFF8
FE713823 0 0014 FFFFFFFFFFFFFFF0
FE208CE3 0 0142 FFFFFFFFFFFFFFF8
FE209CE3 0 0162 FFFFFFFFFFFFFFF8
FE20CCE3 0 0182 FFFFFFFFFFFFFFF8
FE20DCE3 0 01A2 FFFFFFFFFFFFFFF8
FE20ECE3 0 01C2 FFFFFFFFFFFFFFF8
FE20FCE3 0 01E2 FFFFFFFFFFFFFFF8
FFDFF0EF 0 0809 FFFFFFFFFFFFFFFC
004280E7 0 080D 0000000000000004
80000537 0 0C08 FFFFFFFF80000000
FFFFF597 0 1008 FFFFFFFFFFFFF000
8000000F 0 0000 FFFFFFFFFFFFF800
002081B3 1 0000 0000000000000002
FFF08293 1 0000 FFFFFFFFFFFFFFFF
